/* vlog.f */
sram_test_pkg.sv
sram_macro_1rw1r.sv
sram_bank.sv
sram_bus_arbiter.sv
wb_sram_port.sv
scan_test_port.sv
sram_test_chip.sv
sram_test_chip_chk.sv
tb_sram_test_chip.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and check the log for the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_sram_test_chip -f vlog.f > build.log 2>&1 &&
./obj_dir/Vtb_sram_test_chip +verilator+error+limit+1000 > sim.log 2>&1 ||
echo "Build or simulation stopped early, see build.log and sim.log"

cat sim.log 2>/dev/null
grep -q "^Regression passed$" sim.log && echo "Simulation PASS" && exit 0 ||
{ echo "Simulation FAIL"; exit 1; }

/* tb_sram_test_chip.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sram_test_chip
   import sram_test_pkg::*;
;

   localparam int ACK_TIMEOUT  = 20;
   localparam int BUSY_TIMEOUT = 20;

   logic              wb_clk = 1'b0;
   logic              reset;
   logic              wbs_cyc;
   logic              wbs_stb;
   logic              wbs_we;
   logic [3:0]        wbs_sel;
   logic [31:0]       wbs_adr;
   logic [31:0]       wbs_wdata;
   logic              wbs_ack;
   logic [31:0]       wbs_rdata;
   logic              scan_en;
   logic              scan_in;
   logic              scan_load;
   logic              scan_out;
   logic              scan_busy;

   // Reference copy of every macro, indexed by row
   logic [DATA_W-1:0] model [NUM_BANKS][2**ADDR_W];
   logic [31:0]       rng = 32'h93615dcb;
   int                checks = 0;
   int                errors = 0;
   int                test_base = 0;

   always #4 wb_clk = !wb_clk;

   sram_test_chip dut0 (
      .wb_clk_i    (wb_clk),
      .reset_i     (reset),
      .wbs_cyc_i   (wbs_cyc),
      .wbs_stb_i   (wbs_stb),
      .wbs_we_i    (wbs_we),
      .wbs_sel_i   (wbs_sel),
      .wbs_adr_i   (wbs_adr),
      .wbs_dat_i   (wbs_wdata),
      .wbs_ack_o   (wbs_ack),
      .wbs_dat_o   (wbs_rdata),
      .scan_en_i   (scan_en),
      .scan_in_i   (scan_in),
      .scan_load_i (scan_load),
      .scan_out_o  (scan_out),
      .scan_busy_o (scan_busy)
   );

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int bank_depth(input int b);
      return int'(BANK_DEPTH[b]);
   endfunction

   // Initial contents, unique per bank and word
   function automatic logic [31:0] fill_word(input int b, input int w);
      return {6'h2d, 2'(b), 13'(w), 11'(w) ^ 11'h2a5};
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  mask);
      logic [31:0] result;
      result = old_word;
      for (int i = 0; i < 4; i++) begin
         if (mask[i]) begin
            result[i*8 +: 8] = new_word[i*8 +: 8];
         end
      end
      return result;
   endfunction

   task automatic check_word(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("[ERROR] %0d ns %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   task automatic report_test(input string name);
      int errs;
      errs = errors - test_base;
      $display("Test %-16s %s, %0d errors", name, (errs == 0) ? "ok" : "FAILED", errs);
      test_base = errors;
   endtask

   task automatic wb_access(input logic we, input logic [1:0] b, input logic [10:0] w,
                            input logic [3:0] sel, input logic [31:0] wdat,
                            output logic [31:0] rdat);
      int  wait_cycles;
      logic acked;
      @(posedge wb_clk);
      wbs_cyc   <= 1'b1;
      wbs_stb   <= 1'b1;
      wbs_we    <= we;
      wbs_sel   <= sel;
      wbs_adr   <= {17'd0, b, w, 2'b00};
      wbs_wdata <= wdat;
      wait_cycles = 0;
      acked = 1'b0;
      rdat = '0;
      while (!acked && wait_cycles < ACK_TIMEOUT) begin
         @(negedge wb_clk);
         wait_cycles++;
         if (wbs_ack) begin
            acked = 1'b1;
            rdat = wbs_rdata;
         end
      end
      if (!acked) begin
         errors++;
         $display("Timeout: no Wishbone ack for bank %0d word %0d", b, w);
      end
      @(posedge wb_clk);
      wbs_cyc <= 1'b0;
      wbs_stb <= 1'b0;
      wbs_we  <= 1'b0;
   endtask

   task automatic wb_write(input logic [1:0] b, input logic [10:0] w, input logic [3:0] sel,
                           input logic [31:0] data);
      logic [31:0] rdat;
      wb_access(1'b1, b, w, sel, data, rdat);
      if (int'(w) < bank_depth(b)) begin
         model[b][w] = merge_bytes(model[b][w], data, sel);
      end else begin
         check_word("wbs_dat_o", 32'd0, rdat);
      end
   endtask

   task automatic wb_read(input logic [1:0] b, input logic [10:0] w);
      logic [31:0] rdat;
      logic [31:0] exp;
      wb_access(1'b0, b, w, 4'h0, 32'd0, rdat);
      exp = (int'(w) < bank_depth(b)) ? model[b][w] : 32'd0;
      check_word("wbs_dat_o", exp, rdat);
   endtask

   // MSB first in, top bit of the chain sampled before each shift
   task automatic scan_shift(input logic [63:0] din, output logic [63:0] dout);
      for (int i = 0; i < SCAN_W; i++) begin
         @(posedge wb_clk);
         scan_en <= 1'b1;
         scan_in <= din[SCAN_W-1-i];
         @(negedge wb_clk);
         dout[SCAN_W-1-i] = scan_out;
      end
      @(posedge wb_clk);
      scan_en <= 1'b0;
      scan_in <= 1'b0;
   endtask

   task automatic scan_run();
      int wait_cycles;
      @(posedge wb_clk);
      scan_load <= 1'b1;
      @(posedge wb_clk);
      scan_load <= 1'b0;
      @(negedge wb_clk);
      check_word("scan_busy_o", 32'd1, 32'(scan_busy));
      wait_cycles = 0;
      while (scan_busy && wait_cycles < BUSY_TIMEOUT) begin
         @(negedge wb_clk);
         wait_cycles++;
      end
      if (scan_busy) begin
         errors++;
         $display("Timeout: scan access never finished");
      end
   endtask

   task automatic load_write_cmd(input logic [1:0] b, input logic [10:0] a,
                                 input logic [3:0] mask, input logic [31:0] data);
      sram_cmd_u   cmd;
      logic [63:0] old_bits;
      cmd = '0;
      cmd.wr.op = 1'b1;
      cmd.wr.bank = b;
      cmd.wr.addr0 = a;
      cmd.wr.wmask = mask;
      cmd.wr.din = data;
      scan_shift(SCAN_W'(cmd), old_bits);
   endtask

   task automatic load_read_cmd(input logic [1:0] b, input logic [10:0] a0,
                                input logic [10:0] a1);
      sram_cmd_u   cmd;
      logic [63:0] old_bits;
      cmd = '0;
      cmd.rd.op = 1'b0;
      cmd.rd.bank = b;
      cmd.rd.addr0 = a0;
      cmd.rd.addr1 = a1;
      scan_shift(SCAN_W'(cmd), old_bits);
   endtask

   task automatic model_write(input logic [1:0] b, input logic [10:0] a,
                              input logic [3:0] mask, input logic [31:0] data);
      int row;
      row = int'(a) % bank_depth(b);
      model[b][row] = merge_bytes(model[b][row], data, mask);
   endtask

   task automatic unload_and_check(input logic [1:0] b, input logic [10:0] a0,
                                   input logic [10:0] a1);
      logic [63:0] captured;
      scan_shift(64'd0, captured);
      check_word("scan_out_o[63:32]", model[b][int'(a1) % bank_depth(b)], captured[63:32]);
      check_word("scan_out_o[31:0]", model[b][int'(a0) % bank_depth(b)], captured[31:0]);
   endtask

   task automatic scan_write(input logic [1:0] b, input logic [10:0] a,
                             input logic [3:0] mask, input logic [31:0] data);
      load_write_cmd(b, a, mask, data);
      scan_run();
      model_write(b, a, mask, data);
   endtask

   task automatic scan_read(input logic [1:0] b, input logic [10:0] a0, input logic [10:0] a1);
      load_read_cmd(b, a0, a1);
      scan_run();
      unload_and_check(b, a0, a1);
   endtask

   task automatic random_op();
      logic [31:0] r;
      logic [31:0] d;
      logic [1:0]  b;
      logic [10:0] w;
      rng = lcg_step(rng);
      r = rng;
      rng = lcg_step(rng);
      d = rng;
      b = r[26:25];
      w = r[14:4];
      // Mostly in-range Wishbone words, about one in eight raw
      if (r[31:29] != 3'd0) begin
         w = 11'(int'(w) % bank_depth(b));
      end
      // High bits choose the operation and the second scan address
      case (r[28:27])
         2'd0: wb_write(b, w, r[19:16], d);
         2'd1: wb_read(b, w);
         2'd2: scan_write(b, r[14:4], r[23:20], d);
         default: scan_read(b, r[14:4], d[31:21]);
      endcase
   endtask

   initial begin
      wbs_cyc   <= 1'b0;
      wbs_stb   <= 1'b0;
      wbs_we    <= 1'b0;
      wbs_sel   <= 4'h0;
      wbs_adr   <= 32'd0;
      wbs_wdata <= 32'd0;
      scan_en   <= 1'b0;
      scan_in   <= 1'b0;
      scan_load <= 1'b0;
      reset     <= 1'b1;
      repeat (8) @(posedge wb_clk);
      reset <= 1'b0;

      repeat (4) begin
         @(negedge wb_clk);
         check_word("wbs_ack_o", 32'd0, 32'(wbs_ack));
         check_word("scan_busy_o", 32'd0, 32'(scan_busy));
         check_word("scan_out_o", 32'd0, 32'(scan_out));
      end
      report_test("reset_state");

      for (int b = 0; b < NUM_BANKS; b++) begin
         for (int w = 0; w < bank_depth(b); w++) begin
            wb_write(2'(b), 11'(w), 4'hf, fill_word(b, w));
         end
      end
      for (int b = 0; b < NUM_BANKS; b++) begin
         wb_write(2'(b), 11'd3, 4'b0001, 32'h1122_3344);
         wb_write(2'(b), 11'd4, 4'b0110, 32'h5566_7788);
         wb_write(2'(b), 11'(bank_depth(b) - 1), 4'b1010, 32'h99aa_bbcc);
      end
      for (int b = 0; b < NUM_BANKS; b++) begin
         for (int w = 0; w < bank_depth(b); w++) begin
            wb_read(2'(b), 11'(w));
         end
      end
      report_test("wb_masked_rw");

      // Word at the depth would land on row 0 if it got through
      for (int b = 0; b < NUM_BANKS - 1; b++) begin
         wb_write(2'(b), 11'(bank_depth(b)), 4'hf, 32'hdead_beef);
         wb_read(2'(b), 11'(bank_depth(b) + 5));
         wb_read(2'(b), 11'd2047);
         wb_read(2'(b), 11'd0);
         wb_read(2'(b), 11'd5);
      end
      report_test("wb_out_of_range");

      scan_write(2'd1, 11'd7, 4'b0110, 32'hcafe_1234);
      wb_write(2'd1, 11'd100, 4'hf, 32'h0bad_f00d);
      scan_read(2'd1, 11'd7, 11'd100);
      scan_write(2'd0, 11'h1f5, 4'hf, 32'h1357_9bdf);
      wb_read(2'd0, 11'h0f5);
      scan_read(2'd0, 11'h3f5, 11'h305);
      scan_read(2'd3, 11'd2047, 11'd3);
      report_test("scan_access");

      load_read_cmd(2'd2, 11'd10, 11'd20);
      fork
         wb_write(2'd2, 11'd30, 4'b1001, 32'h89ab_cdef);
         scan_run();
      join
      unload_and_check(2'd2, 11'd10, 11'd20);
      wb_read(2'd2, 11'd30);
      load_write_cmd(2'd3, 11'd40, 4'hf, 32'h2468_ace0);
      fork
         wb_read(2'd3, 11'd41);
         scan_run();
      join
      model_write(2'd3, 11'd40, 4'hf, 32'h2468_ace0);
      wb_read(2'd3, 11'd40);
      scan_read(2'd3, 11'd40, 11'd41);
      report_test("contention");

      for (int n = 0; n < 200; n++) begin
         random_op();
      end
      report_test("random_traffic");

      $display("Summary: %0d checks, %0d errors, %0d assertion failures",
               checks, errors, dut0.u_chk.fail_count);
      if (errors == 0 && dut0.u_chk.fail_count == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   // Upper bound on the whole run
   initial begin
      #5_000_000;
      $display("Simulation ran past its time limit");
      $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

/* sram_test_chip_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_test_chip_chk (
   input wire wb_clk_i,
   input wire reset_i,
   input wire cyc_i,
   input wire stb_i,
   input wire ack_i,
   input wire load_i,
   input wire busy_i,
   input wire scan_out_i,
   input wire m0_req_i,
   input wire m1_req_i,
   input wire m0_done_i,
   input wire m1_done_i,
   input wire bank_en_i
);

   int   fail_count = 0;
   logic any_done;

   assign any_done = m0_done_i || m1_done_i;

   // Ack belongs to an active Wishbone cycle
   a_ack_in_cycle: assert property (@(posedge wb_clk_i) disable iff (reset_i)
      ack_i |-> (cyc_i && stb_i))
      else begin
         fail_count++;
         $error("Wishbone ack without cyc and stb");
      end

   // Arbiter free means no access, no done and no rest cycle after a done
   a_ack_latency: assert property (@(posedge wb_clk_i) disable iff (reset_i)
      ($rose(m0_req_i) && !m1_req_i && !bank_en_i && !any_done && !$past(any_done))
      |-> ##2 ack_i)
      else begin
         fail_count++;
         $error("Uncontended in-range Wishbone ack not 2 cycles after strobe");
      end

   a_reset_state: assert property (@(posedge wb_clk_i)
      reset_i |=> (!ack_i && !busy_i && !scan_out_i && !m0_req_i && !m1_req_i
                   && !m0_done_i && !m1_done_i && !bank_en_i))
      else begin
         fail_count++;
         $error("Outputs not low after reset");
      end

   a_busy_needs_load: assert property (@(posedge wb_clk_i) disable iff (reset_i)
      $rose(busy_i) |-> $past(load_i))
      else begin
         fail_count++;
         $error("Scan busy rose without a load");
      end

endmodule

bind sram_test_chip sram_test_chip_chk u_chk (
   .wb_clk_i   (wb_clk_i),
   .reset_i    (reset_i),
   .cyc_i      (wbs_cyc_i),
   .stb_i      (wbs_stb_i),
   .ack_i      (wbs_ack_o),
   .load_i     (scan_load_i),
   .busy_i     (scan_busy_o),
   .scan_out_i (scan_out_o),
   .m0_req_i   (m0_req),
   .m1_req_i   (m1_req),
   .m0_done_i  (m0_done),
   .m1_done_i  (m1_done),
   .bank_en_i  (bank_en)
);

`default_nettype wire

/* sram_test_chip.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_test_chip
   import sram_test_pkg::*;
(
   input  wire                wb_clk_i,
   input  wire                reset_i,
   // Wishbone slave
   input  wire                wbs_cyc_i,
   input  wire                wbs_stb_i,
   input  wire                wbs_we_i,
   input  wire [WMASK_W-1:0]  wbs_sel_i,
   input  wire [31:0]         wbs_adr_i,
   input  wire [DATA_W-1:0]   wbs_dat_i,
   output logic               wbs_ack_o,
   output logic [DATA_W-1:0]  wbs_dat_o,
   // Scan test port
   input  wire                scan_en_i,
   input  wire                scan_in_i,
   input  wire                scan_load_i,
   output logic               scan_out_o,
   output logic               scan_busy_o
);

   // Master 0 is the Wishbone port
   logic               m0_req;
   logic               m0_we;
   logic [BANK_W-1:0]  m0_bank;
   logic [ADDR_W-1:0]  m0_addr0;
   logic [ADDR_W-1:0]  m0_addr1;
   logic [WMASK_W-1:0] m0_wmask;
   logic [DATA_W-1:0]  m0_wdata;
   logic               m0_done;
   logic [DATA_W-1:0]  m0_rdata0;

   // Master 1 is the scan port
   logic               m1_req;
   logic               m1_we;
   logic [BANK_W-1:0]  m1_bank;
   logic [ADDR_W-1:0]  m1_addr0;
   logic [ADDR_W-1:0]  m1_addr1;
   logic [WMASK_W-1:0] m1_wmask;
   logic [DATA_W-1:0]  m1_wdata;
   logic               m1_done;
   logic [DATA_W-1:0]  m1_rdata0;
   logic [DATA_W-1:0]  m1_rdata1;

   logic               bank_en;
   logic               bank_we;
   logic [BANK_W-1:0]  bank_sel;
   logic [ADDR_W-1:0]  bank_addr0;
   logic [ADDR_W-1:0]  bank_addr1;
   logic [WMASK_W-1:0] bank_wmask;
   logic [DATA_W-1:0]  bank_wdata;
   logic [DATA_W-1:0]  bank_dout0;
   logic [DATA_W-1:0]  bank_dout1;

   wb_sram_port u_wb_port (
      .wb_clk_i  (wb_clk_i),
      .reset_i   (reset_i),
      .wbs_cyc_i (wbs_cyc_i),
      .wbs_stb_i (wbs_stb_i),
      .wbs_we_i  (wbs_we_i),
      .wbs_sel_i (wbs_sel_i),
      .wbs_adr_i (wbs_adr_i),
      .wbs_dat_i (wbs_dat_i),
      .wbs_ack_o (wbs_ack_o),
      .wbs_dat_o (wbs_dat_o),
      .req_o     (m0_req),
      .we_o      (m0_we),
      .bank_o    (m0_bank),
      .addr0_o   (m0_addr0),
      .addr1_o   (m0_addr1),
      .wmask_o   (m0_wmask),
      .wdata_o   (m0_wdata),
      .done_i    (m0_done),
      .rdata0_i  (m0_rdata0)
   );

   scan_test_port u_scan_port (
      .wb_clk_i    (wb_clk_i),
      .reset_i     (reset_i),
      .scan_en_i   (scan_en_i),
      .scan_in_i   (scan_in_i),
      .scan_load_i (scan_load_i),
      .scan_out_o  (scan_out_o),
      .scan_busy_o (scan_busy_o),
      .req_o       (m1_req),
      .we_o        (m1_we),
      .bank_o      (m1_bank),
      .addr0_o     (m1_addr0),
      .addr1_o     (m1_addr1),
      .wmask_o     (m1_wmask),
      .wdata_o     (m1_wdata),
      .done_i      (m1_done),
      .rdata0_i    (m1_rdata0),
      .rdata1_i    (m1_rdata1)
   );

   // The Wishbone port has no use for the port 1 word
   sram_bus_arbiter u_arbiter (
      .wb_clk_i     (wb_clk_i),
      .reset_i      (reset_i),
      .m0_req_i     (m0_req),
      .m0_we_i      (m0_we),
      .m0_bank_i    (m0_bank),
      .m0_addr0_i   (m0_addr0),
      .m0_addr1_i   (m0_addr1),
      .m0_wmask_i   (m0_wmask),
      .m0_wdata_i   (m0_wdata),
      .m0_done_o    (m0_done),
      .m0_rdata0_o  (m0_rdata0),
      .m0_rdata1_o  (),
      .m1_req_i     (m1_req),
      .m1_we_i      (m1_we),
      .m1_bank_i    (m1_bank),
      .m1_addr0_i   (m1_addr0),
      .m1_addr1_i   (m1_addr1),
      .m1_wmask_i   (m1_wmask),
      .m1_wdata_i   (m1_wdata),
      .m1_done_o    (m1_done),
      .m1_rdata0_o  (m1_rdata0),
      .m1_rdata1_o  (m1_rdata1),
      .bank_en_o    (bank_en),
      .bank_we_o    (bank_we),
      .bank_sel_o   (bank_sel),
      .bank_addr0_o (bank_addr0),
      .bank_addr1_o (bank_addr1),
      .bank_wmask_o (bank_wmask),
      .bank_wdata_o (bank_wdata),
      .bank_dout0_i (bank_dout0),
      .bank_dout1_i (bank_dout1)
   );

   sram_bank u_bank (
      .wb_clk_i     (wb_clk_i),
      .bank_en_i    (bank_en),
      .bank_we_i    (bank_we),
      .bank_sel_i   (bank_sel),
      .bank_addr0_i (bank_addr0),
      .bank_addr1_i (bank_addr1),
      .bank_wmask_i (bank_wmask),
      .bank_wdata_i (bank_wdata),
      .bank_dout0_o (bank_dout0),
      .bank_dout1_o (bank_dout1)
   );

endmodule

`default_nettype wire

/* scan_test_port.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_test_port
   import sram_test_pkg::*;
(
   input  wire                wb_clk_i,
   input  wire                reset_i,
   // Scan pins
   input  wire                scan_en_i,
   input  wire                scan_in_i,
   input  wire                scan_load_i,
   output logic               scan_out_o,
   output logic               scan_busy_o,
   // Arbiter master side
   output logic               req_o,
   output logic               we_o,
   output logic [BANK_W-1:0]  bank_o,
   output logic [ADDR_W-1:0]  addr0_o,
   output logic [ADDR_W-1:0]  addr1_o,
   output logic [WMASK_W-1:0] wmask_o,
   output logic [DATA_W-1:0]  wdata_o,
   input  wire                done_i,
   input  wire [DATA_W-1:0]   rdata0_i,
   input  wire [DATA_W-1:0]   rdata1_i
);

   logic [SCAN_W-1:0] chain_q;
   logic              busy_q;
   sram_cmd_u         cmd;
   logic              is_write;

   // The chain is frozen while busy so the command stays stable
   always_ff @(posedge wb_clk_i) begin
      if (reset_i) begin
         chain_q <= '0;
         busy_q  <= 1'b0;
      end else if (busy_q) begin
         if (done_i) begin
            // Port 1 word in the upper half, port 0 word in the lower
            chain_q <= {rdata1_i, rdata0_i};
            busy_q  <= 1'b0;
         end
      end else if (scan_load_i) begin
         busy_q <= 1'b1;
      end else if (scan_en_i) begin
         chain_q <= {chain_q[SCAN_W-2:0], scan_in_i};
      end
   end

   assign scan_out_o  = chain_q[SCAN_W-1];
   assign scan_busy_o = busy_q;

   // Command sits in the low bits of the chain
   assign cmd      = chain_q[CMD_W-1:0];
   assign is_write = cmd.wr.op;

   assign req_o   = busy_q;
   assign we_o    = is_write;
   assign bank_o  = is_write ? cmd.wr.bank  : cmd.rd.bank;
   assign addr0_o = is_write ? cmd.wr.addr0 : cmd.rd.addr0;

   // Write carries mask and data, read carries the second address
   assign addr1_o = is_write ? '0 : cmd.rd.addr1;
   assign wmask_o = is_write ? cmd.wr.wmask : '0;
   assign wdata_o = is_write ? cmd.wr.din : '0;

endmodule

`default_nettype wire

/* wb_sram_port.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_sram_port
   import sram_test_pkg::*;
(
   input  wire                wb_clk_i,
   input  wire                reset_i,
   // Wishbone slave
   input  wire                wbs_cyc_i,
   input  wire                wbs_stb_i,
   input  wire                wbs_we_i,
   input  wire [WMASK_W-1:0]  wbs_sel_i,
   input  wire [31:0]         wbs_adr_i,
   input  wire [DATA_W-1:0]   wbs_dat_i,
   output logic               wbs_ack_o,
   output logic [DATA_W-1:0]  wbs_dat_o,
   // Arbiter master side
   output logic               req_o,
   output logic               we_o,
   output logic [BANK_W-1:0]  bank_o,
   output logic [ADDR_W-1:0]  addr0_o,
   output logic [ADDR_W-1:0]  addr1_o,
   output logic [WMASK_W-1:0] wmask_o,
   output logic [DATA_W-1:0]  wdata_o,
   input  wire                done_i,
   input  wire [DATA_W-1:0]   rdata0_i
);

   logic              access;
   logic [BANK_W-1:0] bank;
   logic [ADDR_W-1:0] word;
   logic              in_range;
   logic              oor_ack_q;

   // Byte address split into bank and word
   assign access = wbs_cyc_i && wbs_stb_i;
   assign bank   = wbs_adr_i[14:13];
   assign word   = wbs_adr_i[12:2];

   // Each bank has its own depth
   assign in_range = ({1'b0, word} < BANK_DEPTH[bank]);

   // Out-of-range words are answered here one cycle later
   always_ff @(posedge wb_clk_i) begin
      if (reset_i) begin
         oor_ack_q <= 1'b0;
      end else begin
         oor_ack_q <= access && !in_range && !oor_ack_q;
      end
   end

   // Request follows the strobe and holds until done
   assign req_o   = access && in_range;
   assign we_o    = wbs_we_i;
   assign bank_o  = bank;
   assign addr0_o = word;
   assign addr1_o = '0;
   assign wmask_o = wbs_sel_i;
   assign wdata_o = wbs_dat_i;

   assign wbs_ack_o = done_i || oor_ack_q;
   assign wbs_dat_o = done_i ? rdata0_i : '0;

endmodule

`default_nettype wire

/* sram_bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_bus_arbiter
   import sram_test_pkg::*;
(
   input  wire                wb_clk_i,
   input  wire                reset_i,
   // Master 0, Wishbone port
   input  wire                m0_req_i,
   input  wire                m0_we_i,
   input  wire [BANK_W-1:0]   m0_bank_i,
   input  wire [ADDR_W-1:0]   m0_addr0_i,
   input  wire [ADDR_W-1:0]   m0_addr1_i,
   input  wire [WMASK_W-1:0]  m0_wmask_i,
   input  wire [DATA_W-1:0]   m0_wdata_i,
   output logic               m0_done_o,
   output logic [DATA_W-1:0]  m0_rdata0_o,
   output logic [DATA_W-1:0]  m0_rdata1_o,
   // Master 1, scan port
   input  wire                m1_req_i,
   input  wire                m1_we_i,
   input  wire [BANK_W-1:0]   m1_bank_i,
   input  wire [ADDR_W-1:0]   m1_addr0_i,
   input  wire [ADDR_W-1:0]   m1_addr1_i,
   input  wire [WMASK_W-1:0]  m1_wmask_i,
   input  wire [DATA_W-1:0]   m1_wdata_i,
   output logic               m1_done_o,
   output logic [DATA_W-1:0]  m1_rdata0_o,
   output logic [DATA_W-1:0]  m1_rdata1_o,
   // Bank side
   output logic               bank_en_o,
   output logic               bank_we_o,
   output logic [BANK_W-1:0]  bank_sel_o,
   output logic [ADDR_W-1:0]  bank_addr0_o,
   output logic [ADDR_W-1:0]  bank_addr1_o,
   output logic [WMASK_W-1:0] bank_wmask_o,
   output logic [DATA_W-1:0]  bank_wdata_o,
   input  wire [DATA_W-1:0]   bank_dout0_i,
   input  wire [DATA_W-1:0]   bank_dout1_i
);

   localparam logic [1:0] ST_IDLE   = 2'd0;
   localparam logic [1:0] ST_ACCESS = 2'd1;
   localparam logic [1:0] ST_DONE   = 2'd2;

   logic [1:0] state_q;
   logic       rest_q;
   logic       last_q;
   logic       grant_m1;
   logic       done;

   logic               we_q;
   logic [BANK_W-1:0]  bank_q;
   logic [ADDR_W-1:0]  addr0_q;
   logic [ADDR_W-1:0]  addr1_q;
   logic [WMASK_W-1:0] wmask_q;
   logic [DATA_W-1:0]  wdata_q;

   // Master 1 wins unless master 0 also asks and was not served last
   assign grant_m1 = m1_req_i && (!m0_req_i || !last_q);

   always_ff @(posedge wb_clk_i) begin
      if (reset_i) begin
         state_q <= ST_IDLE;
         rest_q  <= 1'b0;
         last_q  <= 1'b1;
      end else begin
         rest_q <= (state_q == ST_DONE);
         case (state_q)
            ST_IDLE: begin
               // No grant in the cycle right after a done
               if (!rest_q && (m0_req_i || m1_req_i)) begin
                  state_q <= ST_ACCESS;
                  last_q  <= grant_m1;
               end
            end
            ST_ACCESS: state_q <= ST_DONE;
            default:   state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (state_q == ST_IDLE) begin
         we_q    <= grant_m1 ? m1_we_i    : m0_we_i;
         bank_q  <= grant_m1 ? m1_bank_i  : m0_bank_i;
         addr0_q <= grant_m1 ? m1_addr0_i : m0_addr0_i;
         addr1_q <= grant_m1 ? m1_addr1_i : m0_addr1_i;
         wmask_q <= grant_m1 ? m1_wmask_i : m0_wmask_i;
         wdata_q <= grant_m1 ? m1_wdata_i : m0_wdata_i;
      end
   end

   // One access cycle per grant
   assign bank_en_o    = (state_q == ST_ACCESS);
   assign bank_we_o    = we_q;
   assign bank_sel_o   = bank_q;
   assign bank_addr0_o = addr0_q;
   assign bank_addr1_o = addr1_q;
   assign bank_wmask_o = wmask_q;
   assign bank_wdata_o = wdata_q;

   // Done and read data go back to the owner only
   // The master served last owns the access in flight
   assign done        = (state_q == ST_DONE);
   assign m0_done_o   = done && !last_q;
   assign m1_done_o   = done && last_q;
   assign m0_rdata0_o = m0_done_o ? bank_dout0_i : '0;
   assign m0_rdata1_o = m0_done_o ? bank_dout1_i : '0;
   assign m1_rdata0_o = m1_done_o ? bank_dout0_i : '0;
   assign m1_rdata1_o = m1_done_o ? bank_dout1_i : '0;

endmodule

`default_nettype wire

/* sram_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_bank
   import sram_test_pkg::*;
(
   input  wire                wb_clk_i,
   input  wire                bank_en_i,
   input  wire                bank_we_i,
   input  wire [BANK_W-1:0]   bank_sel_i,
   input  wire [ADDR_W-1:0]   bank_addr0_i,
   input  wire [ADDR_W-1:0]   bank_addr1_i,
   input  wire [WMASK_W-1:0]  bank_wmask_i,
   input  wire [DATA_W-1:0]   bank_wdata_i,
   output logic [DATA_W-1:0]  bank_dout0_o,
   output logic [DATA_W-1:0]  bank_dout1_o
);

   logic [NUM_BANKS-1:0] csb0;
   logic [NUM_BANKS-1:0] csb1;
   logic [DATA_W-1:0]    dout0 [NUM_BANKS];
   logic [DATA_W-1:0]    dout1 [NUM_BANKS];
   logic [BANK_W-1:0]    sel_q;

   // Active-low selects, port 1 only runs on reads
   always_comb begin
      for (int i = 0; i < NUM_BANKS; i++) begin
         csb0[i] = !(bank_en_i && (bank_sel_i == BANK_W'(i)));
         csb1[i] = !(bank_en_i && !bank_we_i && (bank_sel_i == BANK_W'(i)));
      end
   end

   // Macro outputs appear one cycle after the access
   always_ff @(posedge wb_clk_i) begin
      if (bank_en_i) begin
         sel_q <= bank_sel_i;
      end
   end

   assign bank_dout0_o = dout0[sel_q];
   assign bank_dout1_o = dout1[sel_q];

   generate
      for (genvar g = 0; g < NUM_BANKS; g++) begin : g_macro
         sram_macro_1rw1r #(
            .DEPTH (int'(BANK_DEPTH[g]))
         ) u_sram (
            .wb_clk_i (wb_clk_i),
            .csb0_i   (csb0[g]),
            .web0_i   (!bank_we_i),
            .wmask0_i (bank_wmask_i),
            .addr0_i  (bank_addr0_i),
            .din0_i   (bank_wdata_i),
            .dout0_o  (dout0[g]),
            .csb1_i   (csb1[g]),
            .addr1_i  (bank_addr1_i),
            .dout1_o  (dout1[g])
         );
      end
   endgenerate

endmodule

`default_nettype wire

/* sram_macro_1rw1r.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_macro_1rw1r
   import sram_test_pkg::*;
#(
   parameter int DEPTH = 256
) (
   input  wire                wb_clk_i,
   // Port 0, read-write
   input  wire                csb0_i,
   input  wire                web0_i,
   input  wire [WMASK_W-1:0]  wmask0_i,
   input  wire [ADDR_W-1:0]   addr0_i,
   input  wire [DATA_W-1:0]   din0_i,
   output logic [DATA_W-1:0]  dout0_o,
   // Port 1, read only
   input  wire                csb1_i,
   input  wire [ADDR_W-1:0]   addr1_i,
   output logic [DATA_W-1:0]  dout1_o
);

   localparam int ROW_W = $clog2(DEPTH);

   logic [DATA_W-1:0] mem [DEPTH];
   logic [ROW_W-1:0]  row0;
   logic [ROW_W-1:0]  row1;

   // Upper address bits are dropped so accesses wrap
   assign row0 = addr0_i[ROW_W-1:0];
   assign row1 = addr1_i[ROW_W-1:0];

   always_ff @(posedge wb_clk_i) begin
      if (!csb0_i) begin
         if (!web0_i) begin
            // Byte lanes with a clear mask bit keep their old value
            for (int b = 0; b < WMASK_W; b++) begin
               if (wmask0_i[b]) begin
                  mem[row0][b*8 +: 8] <= din0_i[b*8 +: 8];
               end
            end
         end else begin
            dout0_o <= mem[row0];
         end
      end
   end

   // Port 1 sees the old word when port 0 writes the same row
   always_ff @(posedge wb_clk_i) begin
      if (!csb1_i) begin
         dout1_o <= mem[row1];
      end
   end

endmodule

`default_nettype wire

/* sram_test_pkg.sv */
`default_nettype none

package sram_test_pkg;

   // Word and address geometry shared by every block
   localparam int DATA_W    = 32;
   localparam int WMASK_W   = DATA_W / 8;
   localparam int ADDR_W    = 11;
   localparam int NUM_BANKS = 4;
   localparam int BANK_W    = 2;

   // Words per macro by bank index
   // Entries are one bit wider than a word address to hold 2048
   localparam logic [NUM_BANKS-1:0][ADDR_W:0] BANK_DEPTH = {
      12'd2048,
      12'd1024,
      12'd512,
      12'd256
   };

   // Scan command and chain sizes
   localparam int CMD_W     = 50;
   localparam int SCAN_W    = 2 * DATA_W;
   localparam int CMD_PAD_W = CMD_W - 1 - BANK_W - 2 * ADDR_W;

   // Write view of the command, op is 1
   typedef struct packed {
      logic               op;
      logic [BANK_W-1:0]  bank;
      logic [ADDR_W-1:0]  addr0;
      logic [WMASK_W-1:0] wmask;
      logic [DATA_W-1:0]  din;
   } sram_cmd_wr_t;

   // Dual-port read view, op is 0
   typedef struct packed {
      logic                 op;
      logic [BANK_W-1:0]    bank;
      logic [ADDR_W-1:0]    addr0;
      logic [ADDR_W-1:0]    addr1;
      logic [CMD_PAD_W-1:0] unused;
   } sram_cmd_rd_t;

   typedef union packed {
      sram_cmd_wr_t wr;
      sram_cmd_rd_t rd;
   } sram_cmd_u;

endpackage

`default_nettype wire
